/* design/pmu_pkg.sv */
/*
 * PMU shared definitions
 * Widths, enums and packed records used by the traffic probes, the
 * event counter bank, the configuration registers and the testbench.
 */
package pmu_pkg;

  // Port and cache geometry
  localparam int ADDR_WIDTH        = 32;
  localparam int LINE_BYTES        = 64;
  localparam int LINE_OFFSET_WIDTH = $clog2(LINE_BYTES);
  localparam int LINE_CNT_WIDTH    = 6;
  localparam int MAX_LINES         = 33;
  // (len + 1) << size needs 12 bits with size up to 3
  localparam int BURST_BYTES_WIDTH = 12;

  // Counters and configuration access
  localparam int CNT_WIDTH      = 32;
  localparam int CFG_ADDR_WIDTH = 5;
  localparam int CFG_DATA_WIDTH = 32;

  // Register map, word addresses
  localparam logic [1:0] CTRL_OFS   = 2'd0;
  localparam logic [1:0] THRESH_OFS = 2'd1;
  localparam logic [1:0] VALUE_OFS  = 2'd2;
  localparam logic [CFG_ADDR_WIDTH-1:0] STATUS_ADDR = 5'd16;

  typedef enum logic [1:0] {
    EV_READ,
    EV_WRITE,
    EV_ANY
  } event_kind_e;

  typedef enum logic {
    CNT_TRANS,
    CNT_LINES
  } count_mode_e;

  typedef enum logic {
    PORT_CPU,
    PORT_MEM
  } port_sel_e;

  typedef enum logic {
    CFG_READ,
    CFG_WRITE
  } cfg_op_e;

  typedef struct packed {
    logic                  valid;
    logic                  write;
    logic [ADDR_WIDTH-1:0] addr;
    logic [7:0]            len;
    logic [2:0]            size;
  } port_req_t;

  typedef struct packed {
    logic                      valid;
    event_kind_e               kind;
    logic [LINE_CNT_WIDTH-1:0] lines;
  } probe_event_t;

  // Occupies bits [4:0] of a control register
  typedef struct packed {
    logic        enable;
    port_sel_e   port;
    event_kind_e kind;
    count_mode_e mode;
  } cnt_ctrl_t;

  typedef struct packed {
    logic                      valid;
    cfg_op_e                   op;
    logic [CFG_ADDR_WIDTH-1:0] addr;
    logic [CFG_DATA_WIDTH-1:0] wdata;
  } cfg_req_t;

  typedef struct packed {
    logic                      valid;
    logic [CFG_DATA_WIDTH-1:0] rdata;
  } cfg_rsp_t;

endpackage

/* design/traffic_probe.sv */
/*
 * Traffic probe
 * Observes one request port of the last-level cache and turns every
 * burst request into an event record one cycle later. The record holds
 * the transfer kind and the number of cache lines the burst touches.
 */
module traffic_probe
  import pmu_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  port_req_t    req_i,
  output probe_event_t event_o
);

  logic [LINE_OFFSET_WIDTH-1:0] line_offset;
  logic [BURST_BYTES_WIDTH-1:0] burst_bytes;
  logic [BURST_BYTES_WIDTH-1:0] last_byte;
  logic [LINE_CNT_WIDTH-1:0]    line_cnt;
  event_kind_e                  req_kind;

  logic                         valid_q;
  event_kind_e                  kind_q;
  logic [LINE_CNT_WIDTH-1:0]    lines_q;

  // Byte position of the burst start inside its cache line
  assign line_offset = req_i.addr[LINE_OFFSET_WIDTH-1:0];

  // Beats times beat size
  assign burst_bytes = (BURST_BYTES_WIDTH'(req_i.len) + 1'b1) << req_i.size;

  // Offset of the last byte, counted from the first line boundary
  assign last_byte = BURST_BYTES_WIDTH'(line_offset) + burst_bytes - 1'b1;

  // Lines spanned up to and including the last byte
  assign line_cnt = LINE_CNT_WIDTH'(last_byte >> LINE_OFFSET_WIDTH) + 1'b1;

  assign req_kind = req_i.write ? EV_WRITE : EV_READ;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i.valid;
    end
  end

  // Payload only loads with a request
  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      kind_q  <= req_kind;
      lines_q <= line_cnt;
    end
  end

  assign event_o.valid = valid_q;
  assign event_o.kind  = kind_q;
  assign event_o.lines = lines_q;

  // 64-bit data path, so at most 8 bytes per beat
  a_size_limit: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    req_i.valid |-> req_i.size <= 3'd3
  );

endmodule

/* design/event_counter_bank.sv */
/*
 * Event counter bank
 * NUM_COUNTER counters, each selecting one probe and one event kind.
 * A counter adds one per request or the request's line count, saturates
 * at all-ones and pulses its hit line on a threshold crossing.
 */
module event_counter_bank
  import pmu_pkg::*;
#(
  parameter int NUM_COUNTER = 4
) (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  probe_event_t                           cpu_event_i,
  input  probe_event_t                           mem_event_i,
  input  cnt_ctrl_t [NUM_COUNTER-1:0]            ctrl_i,
  input  logic [NUM_COUNTER-1:0][CNT_WIDTH-1:0]  threshold_i,
  input  logic [NUM_COUNTER-1:0]                 clear_i,
  output logic [NUM_COUNTER-1:0][CNT_WIDTH-1:0]  count_o,
  output logic [NUM_COUNTER-1:0]                 hit_o
);

  logic [CNT_WIDTH-1:0] cnt_q [NUM_COUNTER];
  logic                 hit_q [NUM_COUNTER];

  for (genvar i = 0; i < NUM_COUNTER; i++) begin : g_cnt
    probe_event_t         src_event;
    logic                 kind_ok;
    logic                 match;
    logic [CNT_WIDTH-1:0] incr;
    logic [CNT_WIDTH:0]   sum;
    logic [CNT_WIDTH-1:0] next_cnt;
    logic                 crossed;

    assign src_event = (ctrl_i[i].port == PORT_CPU) ? cpu_event_i : mem_event_i;

    assign kind_ok = (ctrl_i[i].kind == EV_ANY) || (ctrl_i[i].kind == src_event.kind);

    assign match = ctrl_i[i].enable && src_event.valid && kind_ok;

    assign incr = (ctrl_i[i].mode == CNT_TRANS) ? CNT_WIDTH'(1)
                                                : CNT_WIDTH'(src_event.lines);

    // One extra bit catches the wrap
    assign sum      = {1'b0, cnt_q[i]} + {1'b0, incr};
    assign next_cnt = sum[CNT_WIDTH] ? '1 : sum[CNT_WIDTH-1:0];

    // Only the increment that reaches the threshold counts as a hit
    assign crossed = (threshold_i[i] != '0) &&
                     (cnt_q[i] < threshold_i[i]) &&
                     (next_cnt >= threshold_i[i]);

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        cnt_q[i] <= '0;
        hit_q[i] <= 1'b0;
      end else if (clear_i[i]) begin
        // Clear beats a same-cycle event
        cnt_q[i] <= '0;
        hit_q[i] <= 1'b0;
      end else begin
        hit_q[i] <= match && crossed;
        if (match) begin
          cnt_q[i] <= next_cnt;
        end
      end
    end

    // Control comes from the register block, so check it here
    a_disabled_hold: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      !ctrl_i[i].enable && !clear_i[i] |=> $stable(cnt_q[i])
    );
  end

  always_comb begin
    for (int i = 0; i < NUM_COUNTER; i++) begin
      count_o[i] = cnt_q[i];
      hit_o[i]   = hit_q[i];
    end
  end

endmodule

/* design/pmu_cfg_regs.sv */
/*
 * PMU configuration registers
 * Decodes single-cycle configuration accesses, holds the counter control
 * words and thresholds, clears counters on value writes and keeps the
 * sticky interrupt status. Every access is answered one cycle later.
 */
module pmu_cfg_regs
  import pmu_pkg::*;
#(
  parameter int NUM_COUNTER = 4
) (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  cfg_req_t                               cfg_req_i,
  output cfg_rsp_t                               cfg_rsp_o,
  output cnt_ctrl_t [NUM_COUNTER-1:0]            ctrl_o,
  output logic [NUM_COUNTER-1:0][CNT_WIDTH-1:0]  threshold_o,
  output logic [NUM_COUNTER-1:0]                 clear_o,
  input  logic [NUM_COUNTER-1:0][CNT_WIDTH-1:0]  count_i,
  input  logic [NUM_COUNTER-1:0]                 hit_i,
  output logic [NUM_COUNTER-1:0]                 irq_o
);

  logic                                  req_wr;
  logic                                  req_rd;
  logic                                  stat_we;
  logic [NUM_COUNTER-1:0]                ctrl_we;
  logic [NUM_COUNTER-1:0]                thr_we;
  logic [NUM_COUNTER-1:0]                cnt_clr;
  logic [NUM_COUNTER-1:0]                irq_clr;
  logic [CFG_DATA_WIDTH-1:0]             rdata_d;

  cnt_ctrl_t [NUM_COUNTER-1:0]           ctrl_q;
  logic [NUM_COUNTER-1:0][CNT_WIDTH-1:0] thr_q;
  logic [NUM_COUNTER-1:0]                irq_q;
  logic                                  rsp_valid_q;
  logic [CFG_DATA_WIDTH-1:0]             rdata_q;

  assign req_wr  = cfg_req_i.valid && (cfg_req_i.op == CFG_WRITE);
  assign req_rd  = cfg_req_i.valid && (cfg_req_i.op == CFG_READ);
  assign stat_we = req_wr && (cfg_req_i.addr == STATUS_ADDR);

  // Write-one-to-clear on the status word
  assign irq_clr = stat_we ? cfg_req_i.wdata[NUM_COUNTER-1:0] : '0;

  // Counter i owns word addresses 4i to 4i+3
  always_comb begin
    ctrl_we = '0;
    thr_we  = '0;
    cnt_clr = '0;
    rdata_d = '0;
    if (cfg_req_i.addr == STATUS_ADDR) begin
      rdata_d = CFG_DATA_WIDTH'(irq_q);
    end
    for (int i = 0; i < NUM_COUNTER; i++) begin
      if (cfg_req_i.addr[CFG_ADDR_WIDTH-1:2] == i) begin
        case (cfg_req_i.addr[1:0])
          CTRL_OFS: begin
            ctrl_we[i] = req_wr;
            rdata_d    = CFG_DATA_WIDTH'(ctrl_q[i]);
          end
          THRESH_OFS: begin
            thr_we[i] = req_wr;
            rdata_d   = CFG_DATA_WIDTH'(thr_q[i]);
          end
          VALUE_OFS: begin
            cnt_clr[i] = req_wr;
            rdata_d    = CFG_DATA_WIDTH'(count_i[i]);
          end
          default: rdata_d = '0;
        endcase
      end
    end
    // Writes answer with zero data
    if (!req_rd) begin
      rdata_d = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ctrl_q      <= '0;
      thr_q       <= '0;
      irq_q       <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= cfg_req_i.valid;
      for (int i = 0; i < NUM_COUNTER; i++) begin
        if (ctrl_we[i]) begin
          ctrl_q[i] <= cnt_ctrl_t'(cfg_req_i.wdata[$bits(cnt_ctrl_t)-1:0]);
        end
        if (thr_we[i]) begin
          thr_q[i] <= CNT_WIDTH'(cfg_req_i.wdata);
        end
      end
      // A new hit outweighs a clear in the same cycle
      irq_q <= (irq_q & ~irq_clr) | hit_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cfg_req_i.valid) begin
      rdata_q <= rdata_d;
    end
  end

  assign cfg_rsp_o.valid = rsp_valid_q;
  assign cfg_rsp_o.rdata = rdata_q;
  assign ctrl_o          = ctrl_q;
  assign threshold_o     = thr_q;
  assign clear_o         = cnt_clr;
  assign irq_o           = irq_q;

  a_rsp_after_req: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    cfg_rsp_o.valid |-> $past(cfg_req_i.valid)
  );

endmodule

/* design/host_perf_monitor.sv */
/*
 * Host performance monitor
 * Two probes on the core-side and memory-side cache ports feed a bank
 * of event counters, which is set up and read through a small register
 * block that also raises one interrupt per counter.
 */
module host_perf_monitor
  import pmu_pkg::*;
#(
  parameter int NUM_COUNTER = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  port_req_t              cpu_req_i,
  input  port_req_t              mem_req_i,
  input  cfg_req_t               cfg_req_i,
  output cfg_rsp_t               cfg_rsp_o,
  output logic [NUM_COUNTER-1:0] irq_o
);

  probe_event_t                          cpu_event;
  probe_event_t                          mem_event;
  cnt_ctrl_t [NUM_COUNTER-1:0]           cnt_ctrl;
  logic [NUM_COUNTER-1:0][CNT_WIDTH-1:0] cnt_threshold;
  logic [NUM_COUNTER-1:0][CNT_WIDTH-1:0] cnt_value;
  logic [NUM_COUNTER-1:0]                cnt_clear;
  logic [NUM_COUNTER-1:0]                cnt_hit;

  traffic_probe u_probe_cpu (
    .clk_i   ( clk_i     ),
    .rst_n_i ( rst_n_i   ),
    .req_i   ( cpu_req_i ),
    .event_o ( cpu_event )
  );

  traffic_probe u_probe_mem (
    .clk_i   ( clk_i     ),
    .rst_n_i ( rst_n_i   ),
    .req_i   ( mem_req_i ),
    .event_o ( mem_event )
  );

  event_counter_bank #(
    .NUM_COUNTER ( NUM_COUNTER )
  ) u_counter_bank (
    .clk_i       ( clk_i         ),
    .rst_n_i     ( rst_n_i       ),
    .cpu_event_i ( cpu_event     ),
    .mem_event_i ( mem_event     ),
    .ctrl_i      ( cnt_ctrl      ),
    .threshold_i ( cnt_threshold ),
    .clear_i     ( cnt_clear     ),
    .count_o     ( cnt_value     ),
    .hit_o       ( cnt_hit       )
  );

  pmu_cfg_regs #(
    .NUM_COUNTER ( NUM_COUNTER )
  ) u_cfg_regs (
    .clk_i       ( clk_i         ),
    .rst_n_i     ( rst_n_i       ),
    .cfg_req_i   ( cfg_req_i     ),
    .cfg_rsp_o   ( cfg_rsp_o     ),
    .ctrl_o      ( cnt_ctrl      ),
    .threshold_o ( cnt_threshold ),
    .clear_o     ( cnt_clear     ),
    .count_i     ( cnt_value     ),
    .hit_i       ( cnt_hit       ),
    .irq_o       ( irq_o         )
  );

endmodule

/* testbench/perf_checker.sv */
/*
 * Performance monitor checker
 * Watches the port and configuration signals at the DUT boundary, runs a
 * cycle model of probes, counters and registers, and compares every read
 * response and the interrupt lines against it.
 */
module perf_checker
  import pmu_pkg::*;
#(
  parameter int NUM_COUNTER = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  port_req_t              cpu_req_i,
  input  port_req_t              mem_req_i,
  input  cfg_req_t               cfg_req_i,
  input  cfg_rsp_t               cfg_rsp_i,
  input  logic [NUM_COUNTER-1:0] irq_i,
  output int                     err_count_o
);

  cnt_ctrl_t                 ctrl_m [NUM_COUNTER];
  logic [CNT_WIDTH-1:0]      thr_m  [NUM_COUNTER];
  logic [CNT_WIDTH-1:0]      cnt_m  [NUM_COUNTER];
  logic [NUM_COUNTER-1:0]    hit_m;
  logic [NUM_COUNTER-1:0]    irq_m;
  logic                      ev_valid [2];
  logic                      ev_write [2];
  int                        ev_lines [2];
  logic                      rsp_pending;
  logic [CFG_DATA_WIDTH-1:0] rsp_exp;
  logic [CFG_ADDR_WIDTH-1:0] rsp_addr;
  int                        errors = 0;

  assign err_count_o = errors;

  // Offset in the first line plus the burst bytes, rounded up to lines
  function automatic int burst_lines(port_req_t r);
    int bytes;
    int offset;
    bytes  = (int'(r.len) + 1) << r.size;
    offset = int'(r.addr % LINE_BYTES);
    return (offset + bytes - 1) / LINE_BYTES + 1;
  endfunction

  function automatic logic [CFG_DATA_WIDTH-1:0] model_read(logic [CFG_ADDR_WIDTH-1:0] addr);
    int idx;
    idx = addr / 4;
    if (addr == STATUS_ADDR) begin
      return CFG_DATA_WIDTH'(irq_m);
    end
    if (idx >= NUM_COUNTER || addr % 4 == 3) begin
      return '0;
    end
    case (addr % 4)
      0:       return CFG_DATA_WIDTH'(ctrl_m[idx]);
      1:       return thr_m[idx];
      default: return cnt_m[idx];
    endcase
  endfunction

  always @(posedge clk_i) begin : model_step
    logic                   wr;
    logic                   match;
    logic [NUM_COUNTER-1:0] clr_irq;
    logic [CNT_WIDTH-1:0]   nxt;
    longint                 sum;
    int                     src;
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_COUNTER; i++) begin
        ctrl_m[i] = '0;
        thr_m[i]  = '0;
        cnt_m[i]  = '0;
      end
      hit_m       = '0;
      irq_m       = '0;
      ev_valid[0] = 1'b0;
      ev_valid[1] = 1'b0;
      rsp_pending = 1'b0;
    end else begin
      // Outputs seen here still hold the values of the previous cycle
      if (rsp_pending && !cfg_rsp_i.valid) begin
        $display("Missing response to the configuration access at %0t", $time);
        errors++;
      end else if (rsp_pending && cfg_rsp_i.rdata !== rsp_exp) begin
        $display("FAIL t=%0t cfg_rsp_o.rdata (addr %0d) expected %h actual %h",
                 $time, rsp_addr, rsp_exp, cfg_rsp_i.rdata);
        errors++;
      end else if (!rsp_pending && cfg_rsp_i.valid !== 1'b0) begin
        $display("Configuration response without a request at %0t", $time);
        errors++;
      end
      if (irq_i !== irq_m) begin
        $display("FAIL t=%0t irq_o expected %b actual %b", $time, irq_m, irq_i);
        errors++;
      end

      wr          = cfg_req_i.valid && cfg_req_i.op == CFG_WRITE;
      rsp_pending = cfg_req_i.valid;
      rsp_addr    = cfg_req_i.addr;
      rsp_exp     = (cfg_req_i.valid && !wr) ? model_read(cfg_req_i.addr) : '0;
      clr_irq     = (wr && cfg_req_i.addr == STATUS_ADDR) ?
                    cfg_req_i.wdata[NUM_COUNTER-1:0] : '0;
      irq_m       = (irq_m & ~clr_irq) | hit_m;

      for (int i = 0; i < NUM_COUNTER; i++) begin
        src   = (ctrl_m[i].port == PORT_CPU) ? 0 : 1;
        match = ctrl_m[i].enable && ev_valid[src] &&
                (ctrl_m[i].kind == EV_ANY ||
                 (ctrl_m[i].kind == EV_WRITE && ev_write[src]) ||
                 (ctrl_m[i].kind == EV_READ && !ev_write[src]));
        sum   = longint'(cnt_m[i]) + ((ctrl_m[i].mode == CNT_TRANS) ? 1 : ev_lines[src]);
        nxt   = (sum > longint'(32'hFFFF_FFFF)) ? '1 : sum[CNT_WIDTH-1:0];
        if (wr && cfg_req_i.addr == 4 * i + 2) begin
          cnt_m[i] = '0;
          hit_m[i] = 1'b0;
        end else begin
          hit_m[i] = match && thr_m[i] != 0 && cnt_m[i] < thr_m[i] && nxt >= thr_m[i];
          if (match) begin
            cnt_m[i] = nxt;
          end
        end
        if (wr && cfg_req_i.addr == 4 * i) begin
          ctrl_m[i] = cnt_ctrl_t'(cfg_req_i.wdata[$bits(cnt_ctrl_t)-1:0]);
        end
        if (wr && cfg_req_i.addr == 4 * i + 1) begin
          thr_m[i] = cfg_req_i.wdata;
        end
      end

      // Probe events appear one cycle after the request
      ev_valid[0] = cpu_req_i.valid;
      ev_write[0] = cpu_req_i.write;
      ev_lines[0] = burst_lines(cpu_req_i);
      ev_valid[1] = mem_req_i.valid;
      ev_write[1] = mem_req_i.write;
      ev_lines[1] = burst_lines(mem_req_i);
    end
  end

endmodule

/* testbench/tb_host_perf_monitor.sv */
/*
 * Testbench for the host performance monitor
 * Drives random burst traffic on both ports and register accesses,
 * while perf_checker models the counters and compares the responses.
 */
module tb_host_perf_monitor
  import pmu_pkg::*;
();

  localparam int NUM_COUNTER = 4;
  localparam int RSP_TIMEOUT = 16;

  logic                   clk;
  logic                   rst_n;
  port_req_t              cpu_req;
  port_req_t              mem_req;
  cfg_req_t               cfg_req;
  cfg_rsp_t               cfg_rsp;
  logic [NUM_COUNTER-1:0] irq;
  int                     chk_errors;
  int                     seed;
  int                     errs_before;
  int                     tests_passed;
  int                     tests_failed;

  host_perf_monitor #(
    .NUM_COUNTER ( NUM_COUNTER )
  ) dut0 (
    .clk_i     ( clk     ),
    .rst_n_i   ( rst_n   ),
    .cpu_req_i ( cpu_req ),
    .mem_req_i ( mem_req ),
    .cfg_req_i ( cfg_req ),
    .cfg_rsp_o ( cfg_rsp ),
    .irq_o     ( irq     )
  );

  perf_checker #(
    .NUM_COUNTER ( NUM_COUNTER )
  ) chk0 (
    .clk_i       ( clk        ),
    .rst_n_i     ( rst_n      ),
    .cpu_req_i   ( cpu_req    ),
    .mem_req_i   ( mem_req    ),
    .cfg_req_i   ( cfg_req    ),
    .cfg_rsp_i   ( cfg_rsp    ),
    .irq_i       ( irq        ),
    .err_count_o ( chk_errors )
  );

  always #50 clk = ~clk;

  function automatic logic [CFG_DATA_WIDTH-1:0] ctrl_word(port_sel_e port, event_kind_e kind,
                                                         count_mode_e mode);
    cnt_ctrl_t c;
    c.enable = 1'b1;
    c.port   = port;
    c.kind   = kind;
    c.mode   = mode;
    return CFG_DATA_WIDTH'(c);
  endfunction

  function automatic bit chance(int pct);
    return (($random(seed) & 32'h7fff_ffff) % 100) < pct;
  endfunction

  // Idle, random burst, or maximum burst starting off a line boundary
  function automatic port_req_t next_req(int busy_pct, int long_pct);
    port_req_t r;
    r = '0;
    if (chance(busy_pct)) begin
      r.valid = 1'b1;
      r.write = chance(50);
      r.addr  = $random(seed);
      r.len   = $random(seed);
      r.size  = 3'($random(seed) & 3);
      if (chance(long_pct)) begin
        r.len     = 8'd255;
        r.size    = 3'd3;
        r.addr[0] = 1'b1;
      end
    end
    return r;
  endfunction

  task automatic cfg_access(cfg_op_e op, int addr, logic [CFG_DATA_WIDTH-1:0] wdata);
    int waited;
    @(negedge clk);
    cfg_req.valid = 1'b1;
    cfg_req.op    = op;
    cfg_req.addr  = CFG_ADDR_WIDTH'(addr);
    cfg_req.wdata = wdata;
    @(negedge clk);
    cfg_req = '0;
    waited  = 0;
    while (!cfg_rsp.valid && waited < RSP_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!cfg_rsp.valid) begin
      $display("Timeout: no response to the configuration access at address %0d", addr);
      $display("** FAIL **");
      $finish;
    end
  endtask

  task automatic drive_traffic(int cycles, int busy_pct, int long_pct);
    repeat (cycles) begin
      @(negedge clk);
      cpu_req = next_req(busy_pct, long_pct);
      mem_req = next_req(busy_pct, long_pct);
    end
    @(negedge clk);
    cpu_req = '0;
    mem_req = '0;
    // Last events still have to reach the counters
    repeat (3) @(negedge clk);
  endtask

  task automatic access_counters(cfg_op_e op);
    for (int i = 0; i < NUM_COUNTER; i++) begin
      cfg_access(op, 4 * i + 2, '0);
    end
  endtask

  task automatic finish_test(string name);
    int errs;
    repeat (2) @(negedge clk);
    errs = chk_errors - errs_before;
    if (errs == 0) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d mismatches", name, errs);
    end
    errs_before = chk_errors;
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    cpu_req      = '0;
    mem_req      = '0;
    cfg_req      = '0;
    seed         = 63;
    errs_before  = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    for (int a = 0; a < 32; a++) begin
      cfg_access(CFG_READ, a, '0);
    end
    finish_test("reset values");

    cfg_access(CFG_WRITE, 0, ctrl_word(PORT_CPU, EV_READ, CNT_TRANS));
    cfg_access(CFG_WRITE, 4, ctrl_word(PORT_CPU, EV_WRITE, CNT_TRANS));
    cfg_access(CFG_WRITE, 8, ctrl_word(PORT_MEM, EV_ANY, CNT_TRANS));
    cfg_access(CFG_WRITE, 12, ctrl_word(PORT_MEM, EV_WRITE, CNT_TRANS));
    drive_traffic(150, 50, 0);
    access_counters(CFG_READ);
    finish_test("transaction counting");

    cfg_access(CFG_WRITE, 0, ctrl_word(PORT_CPU, EV_ANY, CNT_LINES));
    cfg_access(CFG_WRITE, 4, ctrl_word(PORT_MEM, EV_READ, CNT_LINES));
    cfg_access(CFG_WRITE, 8, ctrl_word(PORT_MEM, EV_WRITE, CNT_LINES));
    cfg_access(CFG_WRITE, 12, ctrl_word(PORT_CPU, EV_READ, CNT_LINES));
    access_counters(CFG_WRITE);
    drive_traffic(100, 50, 30);
    access_counters(CFG_READ);
    finish_test("line counting");

    cfg_access(CFG_READ, 2, '0);
    cfg_access(CFG_WRITE, 2, '0);
    cfg_access(CFG_READ, 2, '0);
    // Counter 1 is cleared in the middle of the traffic
    fork
      drive_traffic(80, 60, 10);
      begin
        repeat (30) @(negedge clk);
        cfg_access(CFG_WRITE, 6, '0);
      end
    join
    access_counters(CFG_READ);
    finish_test("counter clear");

    cfg_access(CFG_WRITE, 9, 32'd5);
    cfg_access(CFG_WRITE, 8, ctrl_word(PORT_CPU, EV_ANY, CNT_TRANS));
    cfg_access(CFG_WRITE, 10, '0);
    cfg_access(CFG_WRITE, 16, 32'hF);
    drive_traffic(40, 60, 0);
    cfg_access(CFG_READ, 16, '0);
    drive_traffic(20, 60, 0);
    cfg_access(CFG_READ, 16, '0);
    cfg_access(CFG_WRITE, 16, 32'h4);
    cfg_access(CFG_READ, 16, '0);
    finish_test("threshold interrupt");

    cfg_access(CFG_WRITE, 12, '0);
    cfg_access(CFG_WRITE, 14, '0);
    cfg_access(CFG_WRITE, 3, 32'hFFFF_FFFF);
    cfg_access(CFG_WRITE, 21, 32'h1234_5678);
    cfg_access(CFG_WRITE, 31, 32'hFFFF_FFFF);
    drive_traffic(60, 60, 20);
    cfg_access(CFG_READ, 12, '0);
    cfg_access(CFG_READ, 14, '0);
    for (int a = 0; a < 32; a++) begin
      if (a % 4 == 3 || a > 16) begin
        cfg_access(CFG_READ, a, '0);
      end
    end
    finish_test("disabled and unmapped");

    $display("tests passed %0d, failed %0d, mismatches %0d",
             tests_passed, tests_failed, chk_errors);
    if (tests_failed == 0 && chk_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* verilog.f */
design/pmu_pkg.sv
design/traffic_probe.sv
design/event_counter_bank.sv
design/pmu_cfg_regs.sv
design/host_perf_monitor.sv
testbench/perf_checker.sv
testbench/tb_host_perf_monitor.sv
